//--- Makefile
# Verilator build and run of the BCH (15,5) decoder testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module bch_decoder_tb -Mdir obj_dir
	./obj_dir/Vbch_decoder_tb | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
+incdir+include
rtl/bch_pkg.sv
rtl/bch_syndrome.sv
rtl/bch_berlekamp_ibm_4t.sv
rtl/bch_chien_correct.sv
rtl/bch_dec_config.sv
rtl/bch_decoder_top.sv
bench/bch_decoder_tb.sv

//--- bench/bch_decoder_tb.sv
// testbench for the BCH (15,5) decoder
// reference encoder with up to t injected errors, correction and bypass runs,
// random output back-pressure and register readback

`include "bch_params.svh"

module bch_decoder_tb;

  import bch_pkg::*;

  // cycles any single wait may take
  localparam int LIMIT = 2000;
  // generator x^10+x^8+x^5+x^4+x^2+x+1
  localparam word_t GEN_POLY = 15'h0537;

  // what the next output should look like
  typedef struct packed {
    word_t      data;
    ptr_t       ptr;
    logic [1:0] nerr;
    logic       corrected;
  } exp_t;

  logic       iclk;
  logic       ireset;
  logic       in_valid;
  logic       in_ready;
  word_t      in_word;
  logic       out_valid;
  logic       out_ready;
  dec_out_t   out;
  logic       cfg_we;
  cfg_addr_t  cfg_addr;
  logic [7:0] cfg_wdata;
  logic [7:0] cfg_rdata;

  integer seed;
  int     val_errs;
  int     proto_errs;
  int     stall_errs;
  int     corr_seen;
  ptr_t   tag_next;
  exp_t   exp_q[$];

  bch_decoder_top dut_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_word   (in_word),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  initial begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;
  end

  // --------------------------------------------------------------------------
  // protocol checks
  // --------------------------------------------------------------------------

  // held output stays put until taken
  assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out)))
  else begin
    $display("out_valid dropped or out changed before acceptance at time %0t", $time);
    proto_errs++;
  end

  // never more than t errors injected
  assert property (@(posedge iclk) disable iff (ireset) out_valid |-> !out.decfail)
  else begin
    $display("ERR %0t: decfail set on a word with at most t errors", $time);
    val_errs++;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // codeword c(x) = m(x) g(x), bit i is the coefficient of x^i
  function automatic word_t encode(input logic [4:0] msg);
    word_t c;
    c = '0;
    for (int i = 0; i < 5; i++) begin
      if (msg[i]) begin
        c = c ^ (GEN_POLY << i);
      end
    end
    return c;
  endfunction

  task automatic finish_run();
    if (exp_q.size() != 0) begin
      $display("%0d words never came out of the decoder", exp_q.size());
      proto_errs++;
    end
    $display("errors: value %0d, protocol %0d, stall %0d", val_errs, proto_errs, stall_errs);
    if (val_errs + proto_errs + stall_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic report_stall(input string what);
    $display("stall: %s did not happen within %0d cycles", what, LIMIT);
    stall_errs++;
    finish_run();
  endtask

  task automatic check_out(input exp_t e);
    assert (out.data == e.data) else begin
      $display("ERR %0t: data %h, expected %h", $time, out.data, e.data);
      val_errs++;
    end
    // tags follow input order
    assert (out.ptr == e.ptr) else begin
      $display("ERR %0t: tag %0d, expected %0d", $time, out.ptr, e.ptr);
      val_errs++;
    end
    assert (out.nerr == e.nerr) else begin
      $display("ERR %0t: nerr %0d, expected %0d", $time, out.nerr, e.nerr);
      val_errs++;
    end
    assert (out.corrected == e.corrected) else begin
      $display("ERR %0t: corrected %b, expected %b", $time, out.corrected, e.corrected);
      val_errs++;
    end
    if (e.nerr != 2'd0) begin
      corr_seen++;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_word(input int nerr, input logic corr_en);
    logic [4:0] msg;
    word_t      clean;
    word_t      mask;
    int         pos;
    int         t;
    exp_t       e;
    msg   = 5'($random(seed));
    clean = encode(msg);
    mask  = '0;
    // distinct error positions
    while ($countones(mask) < nerr) begin
      pos       = {$random(seed)} % `BCH_N;
      mask[pos] = 1'b1;
    end
    e.data      = corr_en ? clean : (clean ^ mask);
    e.ptr       = tag_next;
    e.nerr      = 2'(nerr);
    e.corrected = corr_en && (nerr != 0);
    tag_next    = tag_next + 1'b1;
    exp_q.push_back(e);
    in_valid = 1'b1;
    in_word  = clean ^ mask;
    t = 0;
    while (!in_ready && t < LIMIT) begin
      @(negedge iclk);
      t++;
    end
    if (!in_ready) begin
      report_stall("input acceptance");
    end
    @(negedge iclk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < LIMIT) begin
      @(negedge iclk);
      t++;
    end
    if (exp_q.size() != 0) begin
      report_stall("draining the decoder");
    end
    // last transfer and its counter update
    repeat (2) @(negedge iclk);
  endtask

  task automatic write_reg(input cfg_addr_t a, input logic [7:0] d);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge iclk);
    cfg_we = 1'b0;
  endtask

  task automatic check_reg(input cfg_addr_t a, input logic [7:0] expv, input string name);
    cfg_addr = a;
    @(negedge iclk);
    assert (cfg_rdata == expv) else begin
      $display("ERR %0t: %s reads %0d, expected %0d", $time, name, cfg_rdata, expv);
      val_errs++;
    end
  endtask

  // --------------------------------------------------------------------------
  // output side, ready decided and transfer checked on the falling edge
  // --------------------------------------------------------------------------

  initial begin
    exp_t e;
    forever begin
      @(negedge iclk);
      // ready about three cycles in four
      out_ready = (($random(seed) & 3) != 0);
      if (out_valid && out_ready && !ireset) begin
        if (exp_q.size() == 0) begin
          $display("decoder delivered a word at time %0t with none pending", $time);
          proto_errs++;
        end else begin
          e = exp_q.pop_front();
          check_out(e);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    seed       = 32'h7ad1_bc60;
    val_errs   = 0;
    proto_errs = 0;
    stall_errs = 0;
    corr_seen  = 0;
    tag_next   = '0;
    ireset     = 1'b1;
    in_valid   = 1'b0;
    in_word    = '0;
    out_ready  = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = CTRL;
    cfg_wdata  = '0;
    repeat (10) @(negedge iclk);
    ireset = 1'b0;

    check_reg(CTRL, 8'd1, "CTRL");
    check_reg(CORR_CNT, 8'd0, "CORR_CNT");
    check_reg(FAIL_CNT, 8'd0, "FAIL_CNT");

    // correction on, 0..3 errors in turn
    for (int i = 0; i < 24; i++) begin
      send_word(i % 4, 1'b1);
    end
    drain();
    check_reg(CORR_CNT, 8'(corr_seen), "CORR_CNT");
    check_reg(FAIL_CNT, 8'd0, "FAIL_CNT");

    // write clears a counter
    write_reg(CORR_CNT, 8'h5a);
    corr_seen = 0;
    check_reg(CORR_CNT, 8'd0, "CORR_CNT after clear");
    write_reg(FAIL_CNT, 8'h5a);
    check_reg(FAIL_CNT, 8'd0, "FAIL_CNT after clear");

    // bypass, raw words out but nerr still reported
    write_reg(CTRL, 8'd0);
    check_reg(CTRL, 8'd0, "CTRL");
    for (int i = 0; i < 16; i++) begin
      send_word((i + 1) % 4, 1'b0);
    end
    drain();
    check_reg(CORR_CNT, 8'(corr_seen), "CORR_CNT");
    check_reg(FAIL_CNT, 8'd0, "FAIL_CNT");

    finish_run();
  end

endmodule

//--- include/bch_params.svh
// BCH (15,5) decoder constants
// field GF(2^4), code length, correction capability and field polynomial

`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

// field width m
`define BCH_M 4

// code length n = 2^m - 1
`define BCH_N 15

// correction capability t
`define BCH_T 3

// syndrome count 2t
`define BCH_T2 6

// field polynomial x^4 + x + 1
`define BCH_IRRPOL 19

`endif

//--- rtl/bch_berlekamp_ibm_4t.sv
// inversionless Berlekamp-Massey unit for binary BCH, t = 3
// four steps per iteration over t iterations with t+1 GF multipliers,
// locator valid 4t+1 cycles after the syndromes are taken

`include "bch_params.svh"

module bch_berlekamp_ibm_4t (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              syn_valid,
  output logic              syn_ready,
  input  bch_pkg::syn_bus_t syn,
  output logic              loc_valid,
  input  logic              loc_ready,
  output bch_pkg::loc_bus_t loc
);

  import bch_pkg::*;

  ibm_state_t state;
  logic [1:0] iter_cnt;
  logic       done;
  logic       syn_acc;

  // window slot k holds syndrome index k - t, slots below t+1 are zero
  gf_t win    [0:`BCH_T+`BCH_T2];
  gf_t lam    [0:`BCH_T];
  gf_t lam_z  [0:`BCH_T];
  gf_t bpol   [0:`BCH_T];
  gf_t bpol_z [0:`BCH_T];
  gf_t mult   [0:`BCH_T];
  gf_t delta;
  gf_t delta_sum;
  gf_t gamma;
  ptr_t ptr_q;
  logic signed [`BCH_M-1:0] kv;

  // no new word while computing or while a locator waits downstream
  assign syn_ready = (state == WAIT) & ~done & ~loc_valid;
  assign syn_acc   = syn_valid & syn_ready;

  // --------------------------------------------------------------------------
  // FSM and result hold
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= RESET;
      iter_cnt  <= '0;
      done      <= 1'b0;
      loc_valid <= 1'b0;
    end else begin
      case (state)
        RESET: state <= WAIT;
        WAIT: begin
          if (syn_acc) begin
            state    <= STEP1;
            iter_cnt <= 2'(`BCH_T - 1);
          end
        end
        STEP1: state <= STEP2;
        STEP2: state <= STEP3;
        STEP3: state <= STEP4;
        STEP4: begin
          if (iter_cnt == '0) begin
            state <= WAIT;
          end else begin
            state    <= STEP1;
            iter_cnt <= iter_cnt - 1'b1;
          end
        end
        default: state <= RESET;
      endcase
      // last step done, valid one cycle later
      done <= (state == STEP4) & (iter_cnt == '0);
      if (done) begin
        loc_valid <= 1'b1;
      end else if (loc_valid & loc_ready) begin
        loc_valid <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // polynomials shifted by z, discrepancy sum
  // --------------------------------------------------------------------------

  always_comb begin
    lam_z[0]  = '0;
    bpol_z[0] = '0;
    for (int i = 1; i <= `BCH_T; i++) begin
      lam_z[i]  = lam[i-1];
      bpol_z[i] = bpol[i-1];
    end
    delta_sum = '0;
    for (int i = 0; i <= `BCH_T; i++) begin
      delta_sum = delta_sum ^ mult[i];
    end
  end

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    // shared multipliers
    // STEP1 lambda*S, STEP2 lambda*gamma, STEP3 z*B*delta
    for (int i = 0; i <= `BCH_T; i++) begin
      mult[i] <= gf_mult((state == STEP3) ? bpol_z[i] : lam[i],
                         (state == STEP1) ? win[`BCH_T+1-i] : delta);
    end
    case (state)
      WAIT: begin
        if (syn_acc) begin
          for (int i = 0; i <= `BCH_T; i++) begin
            win[i]  <= '0;
            lam[i]  <= (i == 0) ? gf_t'(1) : '0;
            bpol[i] <= (i == 0) ? gf_t'(1) : '0;
          end
          for (int j = 1; j <= `BCH_T2; j++) begin
            win[j+`BCH_T] <= syn.s[j];
          end
          gamma <= gf_t'(1);
          kv    <= '0;
          ptr_q <= syn.ptr;
        end
      end
      STEP1: begin
        // next odd syndrome moves into place
        for (int i = 0; i < `BCH_T+`BCH_T2-1; i++) begin
          win[i] <= win[i+2];
        end
        win[`BCH_T+`BCH_T2-1] <= '0;
        win[`BCH_T+`BCH_T2]   <= '0;
        // delta briefly carries gamma for the STEP2 products
        delta <= gamma;
      end
      STEP2: delta <= delta_sum;
      STEP3: begin
        for (int i = 0; i <= `BCH_T; i++) begin
          lam[i] <= mult[i];
        end
        if ((delta != '0) && !kv[`BCH_M-1]) begin
          for (int i = 0; i <= `BCH_T; i++) begin
            bpol[i] <= lam_z[i];
          end
          gamma <= delta;
          kv    <= -kv;
        end else begin
          // B times z^2
          bpol[0] <= '0;
          bpol[1] <= '0;
          for (int i = 2; i <= `BCH_T; i++) begin
            bpol[i] <= bpol[i-2];
          end
          kv <= kv + 4'sd2;
        end
      end
      STEP4: begin
        // gamma*lambda - delta*z*B
        for (int i = 0; i <= `BCH_T; i++) begin
          lam[i] <= lam[i] ^ mult[i];
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i <= `BCH_T; i++) begin
      loc.lambda[i] = lam[i];
    end
    loc.ptr = ptr_q;
  end

endmodule

//--- rtl/bch_chien_correct.sv
// BCH Chien search and correction stage
// 4-entry codeword buffer indexed by tag, serial root search msb first,
// bit flips and failure check of root count against locator degree

`include "bch_params.svh"

module bch_chien_correct (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               buf_we,
  input  bch_pkg::ptr_t      buf_ptr,
  input  bch_pkg::word_t     buf_word,
  input  logic               loc_valid,
  output logic               loc_ready,
  input  bch_pkg::loc_bus_t  loc,
  input  logic               correct_en,
  output logic               out_valid,
  input  logic               out_ready,
  output bch_pkg::dec_out_t  out,
  output bch_pkg::dec_stat_t stat
);

  import bch_pkg::*;

  chien_state_t   state;
  logic [3:0]     pos;
  logic [3:0]     root_cnt;
  logic [1:0]     loc_deg;
  logic [1:0]     deg_q;
  logic           corr_en_q;
  logic           loc_acc;
  logic           out_acc;
  logic           fail;
  ptr_t           ptr_q;
  word_t          err_mask;
  word_t          raw;
  word_t          buf_mem [0:3];
  gf_t [`BCH_T:0] term;
  gf_t            sum;

  always_ff @(posedge iclk) begin
    if (buf_we) begin
      buf_mem[buf_ptr] <= buf_word;
    end
  end

  assign loc_ready = (state == IDLE);
  assign out_valid = (state == HOLD);
  assign loc_acc   = loc_valid & loc_ready;
  assign out_acc   = out_valid & out_ready;

  // locator degree, highest nonzero coefficient
  always_comb begin
    loc_deg = 2'd0;
    for (int j = 1; j <= `BCH_T; j++) begin
      if (loc.lambda[j] != '0) begin
        loc_deg = 2'(j);
      end
    end
    sum = '0;
    for (int j = 0; j <= `BCH_T; j++) begin
      sum = sum ^ term[j];
    end
  end

  // --------------------------------------------------------------------------
  // search FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= IDLE;
      pos      <= '0;
      root_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (loc_acc) begin
            state    <= SEARCH;
            pos      <= 4'(`BCH_N - 1);
            root_cnt <= '0;
          end
        end
        SEARCH: begin
          if (sum == '0) begin
            root_cnt <= root_cnt + 1'b1;
          end
          if (pos == '0) begin
            state <= HOLD;
          end else begin
            pos <= pos - 1'b1;
          end
        end
        HOLD: begin
          if (out_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // step s evaluates lambda(alpha^s), a root flags position n - s
  always_ff @(posedge iclk) begin
    if (loc_acc) begin
      for (int j = 0; j <= `BCH_T; j++) begin
        term[j] <= gf_mult(loc.lambda[j], gf_alpha_pow(j));
      end
      deg_q     <= loc_deg;
      ptr_q     <= loc.ptr;
      corr_en_q <= correct_en;
      err_mask  <= '0;
    end else if (state == SEARCH) begin
      for (int j = 0; j <= `BCH_T; j++) begin
        term[j] <= gf_mult(term[j], gf_alpha_pow(j));
      end
      if (sum == '0) begin
        err_mask[pos] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // output
  // --------------------------------------------------------------------------

  assign raw  = buf_mem[ptr_q];
  assign fail = ({2'b00, deg_q} != root_cnt);

  // failed or bypassed words pass unmodified
  assign out.data      = (corr_en_q & ~fail) ? (raw ^ err_mask) : raw;
  assign out.ptr       = ptr_q;
  assign out.nerr      = deg_q;
  assign out.decfail   = fail;
  assign out.corrected = corr_en_q & ~fail & (deg_q != 2'd0);

  assign stat.done = out_acc & (fail | (deg_q != 2'd0));
  assign stat.fail = out_acc & fail;

endmodule

//--- rtl/bch_dec_config.sv
// BCH decoder register block
// correction enable bit and saturating corrected/failed word counters

module bch_dec_config (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               cfg_we,
  input  bch_pkg::cfg_addr_t cfg_addr,
  input  logic [7:0]         cfg_wdata,
  output logic [7:0]         cfg_rdata,
  input  bch_pkg::dec_stat_t stat,
  output logic               correct_en
);

  import bch_pkg::*;

  logic [7:0] corr_cnt;
  logic [7:0] fail_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      correct_en <= 1'b1;
      corr_cnt   <= '0;
      fail_cnt   <= '0;
    end else begin
      if (cfg_we && (cfg_addr == CTRL)) begin
        correct_en <= cfg_wdata[0];
      end
      // write clears, counters stick at 255
      if (cfg_we && (cfg_addr == CORR_CNT)) begin
        corr_cnt <= '0;
      end else if (stat.done && !stat.fail && (corr_cnt != 8'hff)) begin
        corr_cnt <= corr_cnt + 1'b1;
      end
      if (cfg_we && (cfg_addr == FAIL_CNT)) begin
        fail_cnt <= '0;
      end else if (stat.done && stat.fail && (fail_cnt != 8'hff)) begin
        fail_cnt <= fail_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      CTRL:     cfg_rdata = {7'd0, correct_en};
      CORR_CNT: cfg_rdata = corr_cnt;
      FAIL_CNT: cfg_rdata = fail_cnt;
      default:  cfg_rdata = '0;
    endcase
  end

endmodule

//--- rtl/bch_decoder_top.sv
// BCH (15,5) decoder top level
// syndrome, Berlekamp-Massey and Chien stages chained by valid/ready,
// with the register block beside the Chien stage

module bch_decoder_top (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               in_valid,
  output logic               in_ready,
  input  bch_pkg::word_t     in_word,
  output logic               out_valid,
  input  logic               out_ready,
  output bch_pkg::dec_out_t  out,
  input  logic               cfg_we,
  input  bch_pkg::cfg_addr_t cfg_addr,
  input  logic [7:0]         cfg_wdata,
  output logic [7:0]         cfg_rdata
);

  import bch_pkg::*;

  // syndrome to Berlekamp
  logic      syn_valid;
  logic      syn_ready;
  syn_bus_t  syn;
  // Berlekamp to Chien
  logic      loc_valid;
  logic      loc_ready;
  loc_bus_t  loc;
  // codeword buffer write
  logic      buf_we;
  ptr_t      buf_ptr;
  word_t     buf_word;
  // config side
  logic      correct_en;
  dec_stat_t stat;

  bch_syndrome syndrome_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_word   (in_word),
    .syn_valid (syn_valid),
    .syn_ready (syn_ready),
    .syn       (syn),
    .buf_we    (buf_we),
    .buf_ptr   (buf_ptr),
    .buf_word  (buf_word)
  );

  bch_berlekamp_ibm_4t berlekamp_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .syn_valid (syn_valid),
    .syn_ready (syn_ready),
    .syn       (syn),
    .loc_valid (loc_valid),
    .loc_ready (loc_ready),
    .loc       (loc)
  );

  bch_chien_correct chien_i (
    .iclk       (iclk),
    .ireset     (ireset),
    .buf_we     (buf_we),
    .buf_ptr    (buf_ptr),
    .buf_word   (buf_word),
    .loc_valid  (loc_valid),
    .loc_ready  (loc_ready),
    .loc        (loc),
    .correct_en (correct_en),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out        (out),
    .stat       (stat)
  );

  bch_dec_config config_i (
    .iclk       (iclk),
    .ireset     (ireset),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .stat       (stat),
    .correct_en (correct_en)
  );

endmodule

//--- rtl/bch_pkg.sv
// BCH (15,5) decoder shared types
// field element, buffer tag, stage buses, FSM enums and GF(2^4) arithmetic

`include "bch_params.svh"

package bch_pkg;

  typedef logic [`BCH_M-1:0]   gf_t;
  typedef logic [1:0]          ptr_t;
  typedef logic [`BCH_N-1:0]   word_t;
  // unreduced product of two field elements
  typedef logic [2*`BCH_M-2:0] gf_prod_t;

  // syndromes S1..S6 plus tag
  typedef struct packed {
    gf_t [`BCH_T2:1] s;
    ptr_t            ptr;
  } syn_bus_t;

  // locator lambda0..lambda3 plus tag
  typedef struct packed {
    gf_t [`BCH_T:0] lambda;
    ptr_t           ptr;
  } loc_bus_t;

  typedef struct packed {
    word_t      data;
    ptr_t       ptr;
    logic [1:0] nerr;
    logic       decfail;
    logic       corrected;
  } dec_out_t;

  // done pulses when a word with errors, or a failed word, leaves the decoder
  typedef struct packed {
    logic done;
    logic fail;
  } dec_stat_t;

  typedef enum logic [2:0] {RESET, WAIT, STEP1, STEP2, STEP3, STEP4} ibm_state_t;
  typedef enum logic [1:0] {IDLE, SEARCH, HOLD} chien_state_t;
  typedef enum logic [1:0] {CTRL = 2'd0, CORR_CNT = 2'd1, FAIL_CNT = 2'd2} cfg_addr_t;

  // carry-less multiply, then fold the high bits back with the field polynomial
  function automatic gf_t gf_mult(input gf_t a, input gf_t b);
    gf_prod_t p;
    p = '0;
    for (int i = 0; i < `BCH_M; i++) begin
      if (b[i]) begin
        p = p ^ (gf_prod_t'(a) << i);
      end
    end
    for (int i = 2*`BCH_M-2; i >= `BCH_M; i--) begin
      if (p[i]) begin
        p = p ^ (gf_prod_t'(`BCH_IRRPOL) << (i - `BCH_M));
      end
    end
    return p[`BCH_M-1:0];
  endfunction

  // alpha^e, constant when e is constant
  function automatic gf_t gf_alpha_pow(input int e);
    gf_t r;
    r = gf_t'(1);
    for (int i = 0; i < e; i++) begin
      r = gf_mult(r, gf_t'(2));
    end
    return r;
  endfunction

endpackage

//--- rtl/bch_syndrome.sv
// BCH syndrome stage
// Horner evaluation of the received word at alpha^1..alpha^6, one bit per
// cycle msb first; assigns the buffer tag and stores the word for correction

`include "bch_params.svh"

module bch_syndrome (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              in_valid,
  output logic              in_ready,
  input  bch_pkg::word_t    in_word,
  output logic              syn_valid,
  input  logic              syn_ready,
  output bch_pkg::syn_bus_t syn,
  output logic              buf_we,
  output bch_pkg::ptr_t     buf_ptr,
  output bch_pkg::word_t    buf_word
);

  import bch_pkg::*;

  logic            busy;
  logic [3:0]      bit_cnt;
  logic            in_acc;
  ptr_t            next_tag;
  ptr_t            cur_tag;
  word_t           shreg;
  gf_t [`BCH_T2:1] acc;

  // one word at a time, blocked until the syndromes are taken
  assign in_ready = ~busy & ~syn_valid;
  assign in_acc   = in_valid & in_ready;

  // buffer write carries the tag handed to this word
  assign buf_we   = in_acc;
  assign buf_ptr  = next_tag;
  assign buf_word = in_word;

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy      <= 1'b0;
      bit_cnt   <= '0;
      syn_valid <= 1'b0;
      next_tag  <= '0;
    end else begin
      if (in_acc) begin
        busy     <= 1'b1;
        bit_cnt  <= 4'(`BCH_N - 1);
        // tags wrap mod 4
        next_tag <= next_tag + 1'b1;
      end else if (busy) begin
        bit_cnt <= bit_cnt - 1'b1;
        // last bit consumed
        if (bit_cnt == '0) begin
          busy      <= 1'b0;
          syn_valid <= 1'b1;
        end
      end
      if (syn_valid & syn_ready) begin
        syn_valid <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Horner accumulators
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (in_acc) begin
      shreg   <= in_word;
      cur_tag <= next_tag;
      acc     <= '0;
    end else if (busy) begin
      shreg <= shreg << 1;
      // acc_j = acc_j * alpha^j + r_i
      for (int j = 1; j <= `BCH_T2; j++) begin
        acc[j] <= gf_mult(acc[j], gf_alpha_pow(j)) ^ gf_t'(shreg[`BCH_N-1]);
      end
    end
  end

  assign syn.s   = acc;
  assign syn.ptr = cur_tag;

endmodule
